// File: Makefile
# Verilator build for the convolution unit testbench.

TOP := tb_conv_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f conv_unit.f -o sim

run: compile
	./obj_dir/sim > sim.log; true
	cat sim.log
	grep -qF "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// File: accumulate_activate.sv
`timescale 1ns/1ps
`include "conv_unit_settings.svh"

module accumulate_activate (
	input  logic                      clk,
	input  logic                      arst_n,
	input  conv_unit_pkg::sum_beat_t  sum,
	input  conv_unit_pkg::acc_t       bias,
	input  conv_unit_pkg::acc_t       partial_in,
	input  logic                      accu_enable,
	input  logic                      relu_enable,
	output conv_unit_pkg::result_t    result
);
	import conv_unit_pkg::*;

	acc_t chained;
	acc_t total;
	acc_t activated;
	acc_t result_data;
	logic result_valid;

	// Partial sum from the neighbouring unit only when chaining.
	assign chained = accu_enable ? partial_in : '0;
	assign total = sum.data + bias + chained;

	// ReLU.
	assign activated = (relu_enable && total[`CU_ACC_WIDTH-1]) ? '0 : total;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= sum.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (sum.valid) begin
			result_data <= activated;
		end
	end

	assign result = '{valid: result_valid, data: result_data};

endmodule

// File: conv_mac.sv
`timescale 1ns/1ps
`include "conv_unit_settings.svh"

module conv_mac (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      enable,
	input  conv_unit_pkg::weight_t    weights [`CU_TAPS],
	input  conv_unit_pkg::pixel_t     pixels [`CU_TAPS],
	output conv_unit_pkg::sum_beat_t  sum
);
	import conv_unit_pkg::*;

	acc_t products_next [`CU_TAPS];
	acc_t products [`CU_TAPS];
	logic products_valid;
	acc_t products_total;
	acc_t sum_data;
	logic sum_valid;

	// **************************************************
	// Stage 1, one product per tap pair
	// **************************************************

	// Weight sign-extends, pixel zero-extends.
	always_comb begin
		for (int i = 0; i < `CU_TAPS; i++) begin
			products_next[i] = acc_t'(weights[i]) * acc_t'(pixels[i]);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			products_valid <= 1'b0;
		end else begin
			products_valid <= enable;
		end
	end

	always_ff @(posedge clk) begin
		if (enable) begin
			products <= products_next;
		end
	end

	// **************************************************
	// Stage 2, sum of all products
	// **************************************************

	always_comb begin
		products_total = '0;
		for (int i = 0; i < `CU_TAPS; i++) begin
			products_total = products_total + products[i];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= products_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (products_valid) begin
			sum_data <= products_total;
		end
	end

	assign sum = '{valid: sum_valid, data: sum_data};

	a_sum_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		sum.valid |-> !$isunknown(sum.data)
	) else $error("conv_mac: valid sum carries unknown bits");

endmodule

// File: conv_unit.f
+incdir+.
conv_unit_pkg.sv
weight_memory.sv
tap_window.sv
conv_mac.sv
accumulate_activate.sv
conv_unit.sv
tb_conv_unit.sv

// File: conv_unit.sv
`timescale 1ns/1ps
`include "conv_unit_settings.svh"

module conv_unit (
	input  logic                          clk,
	input  logic                          arst_n,
	input  conv_unit_pkg::host_write_t    wr,
	input  logic                          wm_read,
	input  logic [`CU_WM_ADDR_WIDTH-1:0]  wm_address,
	input  conv_unit_pkg::pixel_beat_t    pixel,
	input  logic                          conv_enable,
	input  conv_unit_pkg::acc_t           bias,
	input  conv_unit_pkg::acc_t           partial_in,
	input  logic                          accu_enable,
	input  logic                          relu_enable,
	output conv_unit_pkg::result_t        result
);
	import conv_unit_pkg::*;

	weight_beat_t wm_beat;
	weight_t      weight_taps [`CU_TAPS];
	pixel_t       pixel_taps [`CU_TAPS];
	sum_beat_t    mac_sum;

	// **************************************************
	// Producer and windows
	// **************************************************

	weight_memory weight_mem (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr      (wr),
		.rd      (wm_read),
		.rd_addr (wm_address),
		.beat    (wm_beat)
	);

	tap_window #(.payload_t(weight_t)) weight_window (
		.clk    (clk),
		.arst_n (arst_n),
		.shift  (wm_beat.valid),
		.din    (wm_beat.data),
		.taps   (weight_taps)
	);

	tap_window #(.payload_t(pixel_t)) pixel_window (
		.clk    (clk),
		.arst_n (arst_n),
		.shift  (pixel.valid),
		.din    (pixel.data),
		.taps   (pixel_taps)
	);

	// **************************************************
	// Arithmetic
	// **************************************************

	conv_mac mac (
		.clk     (clk),
		.arst_n  (arst_n),
		.enable  (conv_enable),
		.weights (weight_taps),
		.pixels  (pixel_taps),
		.sum     (mac_sum)
	);

	accumulate_activate accum (
		.clk         (clk),
		.arst_n      (arst_n),
		.sum         (mac_sum),
		.bias        (bias),
		.partial_in  (partial_in),
		.accu_enable (accu_enable),
		.relu_enable (relu_enable),
		.result      (result)
	);

endmodule

// File: conv_unit_pkg.sv
`include "conv_unit_settings.svh"

package conv_unit_pkg;

	// **************************************************
	// Scalar types
	// **************************************************

	typedef logic signed [`CU_DATA_WIDTH-1:0] weight_t;

	// Pixels are unsigned, zero-extended before the multiply.
	typedef logic [`CU_DATA_WIDTH-1:0] pixel_t;

	typedef logic signed [`CU_ACC_WIDTH-1:0] acc_t;

	// **************************************************
	// Beats between blocks
	// **************************************************

	typedef struct packed {
		logic    valid;
		weight_t data;
	} weight_beat_t;

	typedef struct packed {
		logic   valid;
		pixel_t data;
	} pixel_beat_t;

	typedef struct packed {
		logic                         enable;
		logic [`CU_WM_ADDR_WIDTH-1:0] address;
		weight_t                      data;
	} host_write_t;

	// Raw sum of products.
	typedef struct packed {
		logic valid;
		acc_t data;
	} sum_beat_t;

	// Unit output after bias, chaining and ReLU.
	typedef struct packed {
		logic valid;
		acc_t data;
	} result_t;

endpackage

// File: conv_unit_settings.svh
`ifndef CONV_UNIT_SETTINGS_SVH
`define CONV_UNIT_SETTINGS_SVH

// Kernel edge, 3 by default. 5 works as well.
`define CU_KERNEL_SIZE 3

// Taps in one window.
`define CU_TAPS ((`CU_KERNEL_SIZE) * (`CU_KERNEL_SIZE))

// Weight and pixel width.
`define CU_DATA_WIDTH 8

// Accumulator width.
`define CU_ACC_WIDTH 32

// Weight store size.
`define CU_WM_DEPTH 256
`define CU_WM_ADDR_WIDTH $clog2(`CU_WM_DEPTH)

`endif

// File: conv_unit_testdata.txt
# W addr data | R addr | P pixel | X count of LCG pixels
# C bias partial accu relu expected   (all values decimal)
# Window ordering, one-hot weight at tap 0 then tap 1
W 0 1
R 0
P 11
P 12
P 13
P 14
P 15
P 16
P 17
P 18
P 19
C 0 0 0 0 19
W 1 0
R 1
C 5 0 0 0 23
# Weight round trip with unit pixels, bias and chaining
W 2 1
W 3 2
W 4 3
W 5 4
W 6 5
W 7 6
W 8 7
W 9 8
W 10 9
R 2
R 3
R 4
R 5
R 6
R 7
R 8
R 9
R 10
P 1
P 1
P 1
P 1
P 1
P 1
P 1
P 1
P 1
C 10 0 0 0 55
C 10 100 1 0 155
C 10 100 0 0 55
# ReLU with a negative weight and negative bias
W 11 -3
R 11
C -100 0 0 1 0
C -100 0 0 0 -59
# Pipelined random stream
X 12

// File: tap_window.sv
`timescale 1ns/1ps
`include "conv_unit_settings.svh"

module tap_window #(
	parameter type payload_t = logic [`CU_DATA_WIDTH-1:0]
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     shift,
	input  payload_t din,
	output payload_t taps [`CU_TAPS]
);

	// Tap 0 takes the new entry, the rest move up by one.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CU_TAPS; i++) begin
				taps[i] <= '0;
			end
		end else if (shift) begin
			taps[0] <= din;
			for (int i = 1; i < `CU_TAPS; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

	// **************************************************
	// Checks
	// **************************************************

	// Unknown input would poison every later product.
	a_din_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		shift |-> !$isunknown(din)
	) else $error("tap_window: unknown data shifted in");

endmodule

// File: tb_conv_unit.sv
`timescale 1ns/1ps
`include "conv_unit_settings.svh"

module tb_conv_unit;
	import conv_unit_pkg::*;

	logic                         clk;
	logic                         arst_n;
	host_write_t                  wr;
	logic                         wm_read;
	logic [`CU_WM_ADDR_WIDTH-1:0] wm_address;
	pixel_beat_t                  pixel;
	logic                         conv_enable;
	acc_t                         bias;
	acc_t                         partial_in;
	logic                         accu_enable;
	logic                         relu_enable;
	result_t                      result;

	int          errors = 0;
	int          cycles = 0;
	int          cycle_limit = 0;
	logic [31:0] lcg_state = 32'hce31_7750;
	int          mem_model [`CU_WM_DEPTH];
	int          wwin [`CU_TAPS];
	int          pwin [`CU_TAPS];
	int          pending [$];

	conv_unit DUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Watchdog.
	always @(posedge clk) begin
		cycles++;
		if (cycle_limit != 0 && cycles > cycle_limit) begin
			$display("Timeout after %0d cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int model_conv(int b, int p, int accu, int relu);
		longint s;
		s = 0;
		for (int i = 0; i < `CU_TAPS; i++) begin
			s += longint'(wwin[i]) * longint'(pwin[i]);
		end
		s += b + (accu != 0 ? p : 0);
		if (relu != 0 && s < 0) begin
			s = 0;
		end
		return int'(s);
	endfunction

	function automatic void shift_model(ref int win [`CU_TAPS], input int v);
		for (int i = `CU_TAPS - 1; i > 0; i--) begin
			win[i] = win[i-1];
		end
		win[0] = v;
	endfunction

	task automatic check_value(string name, int got, int exp);
		assert (got == exp) else begin
			errors++;
			$display("Error %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// ************************************************
	// Command runners
	// ************************************************

	task automatic push_pixel(int v);
		pixel = '{valid: 1'b1, data: pixel_t'(v)};
		shift_model(pwin, v & 8'hff);
		next_cycle();
		pixel.valid = 1'b0;
	endtask

	task automatic run_stream(int count);
		int v;
		// Plain sums, no bias or ReLU.
		bias = '0;
		partial_in = '0;
		accu_enable = 1'b0;
		relu_enable = 1'b0;
		for (int i = 0; i < count + 3; i++) begin
			if (i >= 3) begin
				assert (result.valid) else begin
					errors++;
					$display("Result valid missing in pipelined stream at %0t", $time);
				end
				check_value("result.data", result.data, pending.pop_front());
			end
			if (i < count) begin
				v = int'(lcg_next() >> 16) & 8'hff;
				pending.push_back(model_conv(0, 0, 0, 0));
				pixel = '{valid: 1'b1, data: pixel_t'(v)};
				conv_enable = 1'b1;
				shift_model(pwin, v);
			end else begin
				pixel.valid = 1'b0;
				conv_enable = 1'b0;
			end
			next_cycle();
		end
	endtask

	task automatic run_conv(int b, int p, int accu, int relu, int exp_file);
		int exp_model;
		exp_model = model_conv(b, p, accu, relu);
		assert (exp_model == exp_file) else begin
			errors++;
			$display("Data file expects %0d but the model gives %0d", exp_file, exp_model);
		end
		bias = b;
		partial_in = p;
		accu_enable = (accu != 0);
		relu_enable = (relu != 0);
		conv_enable = 1'b1;
		next_cycle();
		conv_enable = 1'b0;
		next_cycle();
		next_cycle();
		assert (result.valid) else begin
			errors++;
			$display("Result valid missing three cycles after conv_enable at %0t", $time);
		end
		check_value("result.data", result.data, exp_model);
	endtask

	// ************************************************
	// Main sequence
	// ************************************************

	initial begin
		int    fd;
		int    n;
		byte   cmd;
		int    a0, a1, a2, a3, a4;
		string line;
		wr = '0;
		wm_read = 1'b0;
		wm_address = '0;
		pixel = '0;
		conv_enable = 1'b0;
		bias = '0;
		partial_in = '0;
		accu_enable = 1'b0;
		relu_enable = 1'b0;
		arst_n = 1'b0;
		for (int i = 0; i < `CU_TAPS; i++) begin
			wwin[i] = 0;
			pwin[i] = 0;
		end

		// First pass sizes the watchdog.
		fd = $fopen("conv_unit_testdata.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the test data file");
		end else begin
			n = 0;
			while ($fgets(line, fd)) begin
				if (line.len() > 1 && line[0] != "#") begin
					n++;
				end
			end
			$fclose(fd);
			cycle_limit = 20 * n + 100;
		end

		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		next_cycle();
		assert (!result.valid) else begin
			errors++;
			$display("Result valid is set right after reset");
		end

		fd = $fopen("conv_unit_testdata.txt", "r");
		while (fd != 0 && $fgets(line, fd)) begin
			if (line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%c %d %d %d %d %d", cmd, a0, a1, a2, a3, a4);
				case (cmd)
					"W": begin
						wr = '{enable: 1'b1, address: a0[`CU_WM_ADDR_WIDTH-1:0],
							data: weight_t'(a1)};
						mem_model[a0] = a1;
						next_cycle();
						wr.enable = 1'b0;
					end
					"R": begin
						wm_read = 1'b1;
						wm_address = a0[`CU_WM_ADDR_WIDTH-1:0];
						shift_model(wwin, mem_model[a0]);
						next_cycle();
						wm_read = 1'b0;
						// Beat, then the window shift.
						next_cycle();
						next_cycle();
					end
					"P": push_pixel(a0);
					"C": run_conv(a0, a1, a2, a3, a4);
					"X": run_stream(a0);
					default: begin
						errors++;
						$display("Unknown command in test data: %s", line);
					end
				endcase
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: weight_memory.sv
`timescale 1ns/1ps
`include "conv_unit_settings.svh"

module weight_memory (
	input  logic                          clk,
	input  logic                          arst_n,
	input  conv_unit_pkg::host_write_t    wr,
	input  logic                          rd,
	input  logic [`CU_WM_ADDR_WIDTH-1:0]  rd_addr,
	output conv_unit_pkg::weight_beat_t   beat
);
	import conv_unit_pkg::*;

	weight_t mem [`CU_WM_DEPTH];

	// Host side.
	always_ff @(posedge clk) begin
		if (wr.enable) begin
			mem[wr.address] <= wr.data;
		end
	end

	// Registered read, valid follows rd by one cycle.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			beat.valid <= 1'b0;
			beat.data  <= '0;
		end else begin
			beat.valid <= rd;
			if (rd) begin
				beat.data <= mem[rd_addr];
			end
		end
	end

	// **************************************************
	// Checks
	// **************************************************

	// Single port, so host write and read must not collide.
	a_no_rd_wr_collision: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(rd && wr.enable)
	) else $error("weight_memory: read and write in the same cycle");

	a_rd_addr_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		rd |-> (rd_addr < `CU_WM_DEPTH)
	) else $error("weight_memory: read address out of range");

	a_wr_addr_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		wr.enable |-> (wr.address < `CU_WM_DEPTH)
	) else $error("weight_memory: write address out of range");

endmodule
